//--- tb.f
+incdir+rtl
rtl/cam_pkg.sv
rtl/ov7670_capture.sv
rtl/frame_buffer_arbiter.sv
rtl/frame_buffer.sv
rtl/vga_scan.sv
rtl/target_finder.sv
rtl/cam_top.sv
test/tb_cam_top.sv

//--- Makefile
# Verilator flow for the camera frame path testbench
# any variable can be overridden, e.g. make sim LOG=run.log

TOP       ?= tb_cam_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -Wno-fatal -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Done: no errors" $(LOG) || (echo "simulation gave no result"; exit 1)
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- test/tb_cam_top.sv
/* testbench for the camera to vga frame path
   sends camera frames, watches the vga raster and checks pixels and target reports */
`include "cam_macros.svh"

module tb_cam_top;
  timeunit 1ns;
  timeprecision 1ps;
  import cam_pkg::*;

  localparam int NPIX        = `FB_DEPTH;
  localparam int VS_CLKS     = 4;
  localparam int LINE_GAP    = 6;
  // column bins 0..4, 5..10, 11..15
  localparam int LEFT_LAST   = 4;
  localparam int RIGHT_FIRST = 11;
  // two clocks per display pixel
  localparam int FRAME_CLKS  = 2 * (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK) *
                               (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK);
  // vsync pulse, gap, then two bytes per pixel plus a gap per line
  localparam int CAM_CLKS    = VS_CLKS + LINE_GAP + `CAM_HEIGHT * (2 * `CAM_WIDTH + LINE_GAP);
  // each checked frame waits at most two display frames
  localparam int CHECKED     = 7;
  localparam int SENT        = 9;
  localparam int TIMEOUT_CYCLES = 8 + CHECKED * 2 * FRAME_CLKS + SENT * CAM_CLKS + 256;

  logic                clk;
  logic                arst_n;
  logic                cam_vsync;
  logic                cam_href;
  logic [7:0]          cam_data;
  logic [7:0]          vga_r;
  logic [7:0]          vga_g;
  logic [7:0]          vga_b;
  logic                vga_hsync_n;
  logic                vga_vsync_n;
  logic                vga_blank_n;
  logic                vga_pix_clk;
  logic [`FB_ADDR_W:0] target_count;
  target_dir_e         target_dir;
  logic                overrun;

  // frame as sent by the camera, r g b nibbles
  logic [11:0] cam_px [0:NPIX-1];
  // 24-bit colour seen on the vga outputs
  logic [23:0] shown [0:NPIX-1];
  logic [31:0] lcg_state;
  int          errors;
  int          checks;
  int          cycles;

  cam_top dut_i (
    .clk(clk), .arst_n(arst_n),
    .cam_vsync(cam_vsync), .cam_href(cam_href), .cam_data(cam_data),
    .vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b),
    .vga_hsync_n(vga_hsync_n), .vga_vsync_n(vga_vsync_n),
    .vga_blank_n(vga_blank_n), .vga_pix_clk(vga_pix_clk),
    .target_count(target_count), .target_dir(target_dir), .overrun(overrun)
  );

  // 25 MHz
  always #20 clk = ~clk;

  // run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: tests still running after %0d cycles", cycles);
      $display("Done: errors found");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic orange_window(input logic [11:0] p);
    return (p[11:8] >= 4'(`ORANGE_R_MIN)) &&
           (p[7:4] >= 4'(`ORANGE_G_MIN)) && (p[7:4] <= 4'(`ORANGE_G_MAX)) &&
           (p[3:0] <= 4'(`ORANGE_B_MAX));
  endfunction

  // magenta for targets, then each nibble doubled
  function automatic logic [23:0] vga_colour(input logic [11:0] p);
    logic [11:0] q;
    q = orange_window(p) ? 12'hf0f : p;
    return {q[11:8], q[11:8], q[7:4], q[7:4], q[3:0], q[3:0]};
  endfunction

  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
    checks++;
    if (got !== exp) begin
      $display("FAIL %s: expected %0h, actual %0h", name, exp, got);
      errors++;
    end
  endtask

  // whole frame of ordinary colours
  task automatic fill_random();
    logic [31:0] r32;
    logic [11:0] p;
    for (int a = 0; a < NPIX; a++) begin
      r32 = lcg_next();
      p = r32[19:8];
      // blue above 7 keeps it out of the orange window
      if (orange_window(p)) begin
        p[3:0] = p[3:0] | 4'h8;
      end
      cam_px[a] = p;
    end
  endtask

  task automatic put_orange(input int x, input int y);
    logic [31:0] r32;
    r32 = lcg_next();
    cam_px[y * `CAM_WIDTH + x] = {2'b11, r32[1:0], 4'(4 + r32[9:4] % 6), 2'b00, r32[3:2]};
  endtask

  // vsync pulse then the given number of href lines
  task automatic send_frame(input int lines);
    int a;
    @(posedge clk);
    cam_vsync <= 1'b1;
    repeat (VS_CLKS) @(posedge clk);
    cam_vsync <= 1'b0;
    repeat (LINE_GAP) @(posedge clk);
    for (int y = 0; y < lines; y++) begin
      for (int x = 0; x < `CAM_WIDTH; x++) begin
        a = y * `CAM_WIDTH + x;
        // high nibble of the first byte is unused
        cam_href <= 1'b1;
        cam_data <= {~cam_px[a][11:8], cam_px[a][11:8]};
        @(posedge clk);
        cam_data <= cam_px[a][7:0];
        @(posedge clk);
      end
      cam_href <= 1'b0;
      cam_data <= 8'h00;
      repeat (LINE_GAP) @(posedge clk);
    end
  endtask

  // returns mid-cycle just after the vga vsync falls
  task automatic wait_vsync_fall();
    logic prev;
    @(negedge clk);
    prev = vga_vsync_n;
    @(negedge clk);
    while (!(prev && !vga_vsync_n)) begin
      prev = vga_vsync_n;
      @(negedge clk);
    end
  endtask

  // colour is steady while the pixel clock is low
  // hsync clocks and lit blanking clocks counted from the first active pixel on
  task automatic capture_display(output int hs_low, output int lit_blank);
    int n;
    n = 0;
    hs_low = 0;
    lit_blank = 0;
    while (n < NPIX) begin
      @(negedge clk);
      if (!vga_pix_clk && vga_blank_n) begin
        shown[n] = {vga_r, vga_g, vga_b};
        n++;
      end
      if (n > 0 && !vga_hsync_n) begin
        hs_low++;
      end
      if (n > 0 && !vga_blank_n && {vga_r, vga_g, vga_b} !== 24'h0) begin
        lit_blank++;
      end
    end
  endtask

  task automatic predict_report(output logic [`FB_ADDR_W:0] cnt, output target_dir_e dir);
    int left;
    int mid;
    int right;
    int x;
    left = 0;
    mid = 0;
    right = 0;
    for (int a = 0; a < NPIX; a++) begin
      x = a % `CAM_WIDTH;
      if (orange_window(cam_px[a])) begin
        if (x <= LEFT_LAST) begin
          left++;
        end else if (x < RIGHT_FIRST) begin
          mid++;
        end else begin
          right++;
        end
      end
    end
    cnt = (`FB_ADDR_W + 1)'(left + mid + right);
    // a strict winner, otherwise center
    if (left + mid + right == 0) begin
      dir = DIR_NONE;
    end else if (left > mid && left > right) begin
      dir = DIR_LEFT;
    end else if (right > left && right > mid) begin
      dir = DIR_RIGHT;
    end else begin
      dir = DIR_CENTER;
    end
  endtask

  // first display frame read wholly after the capture, then its report
  task automatic check_next_frame(input string name);
    logic [`FB_ADDR_W:0] exp_cnt;
    target_dir_e         exp_dir;
    int                  hs_low;
    int                  lit_blank;
    wait_vsync_fall();
    capture_display(hs_low, lit_blank);
    for (int a = 0; a < NPIX; a++) begin
      compare_value($sformatf("%s pixel %0d", name, a), vga_colour(cam_px[a]), shown[a]);
    end
    // one full hsync pulse between each pair of active lines
    compare_value($sformatf("%s hsync clocks", name),
                  (`CAM_HEIGHT - 1) * 2 * `H_SYNC, hs_low);
    // colour is black whenever blanking
    compare_value($sformatf("%s lit blanking clocks", name), 0, lit_blank);
    // count and direction publish with the next vsync fall
    wait_vsync_fall();
    predict_report(exp_cnt, exp_dir);
    compare_value($sformatf("%s count", name), exp_cnt, target_count);
    compare_value($sformatf("%s direction", name), exp_dir, target_dir);
  endtask

  task automatic test_reset();
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    compare_value("reset vga_hsync_n", 1'b1, vga_hsync_n);
    compare_value("reset vga_vsync_n", 1'b1, vga_vsync_n);
    compare_value("reset vga_blank_n", 1'b0, vga_blank_n);
    compare_value("reset vga_pix_clk", 1'b0, vga_pix_clk);
    compare_value("reset wr_valid", 1'b0, dut_i.wr_valid);
    compare_value("reset rd_valid", 1'b0, dut_i.rd_valid);
    compare_value("reset overrun", 1'b0, overrun);
    compare_value("reset target_count", 0, target_count);
    compare_value("reset target_dir", DIR_NONE, target_dir);
  endtask

  task automatic test_round_trip();
    fill_random();
    send_frame(`CAM_HEIGHT);
    check_next_frame("round_trip");
  endtask

  task automatic test_orange_right();
    fill_random();
    put_orange(11, 0);
    put_orange(12, 3);
    put_orange(15, 5);
    put_orange(13, 7);
    put_orange(14, 9);
    put_orange(11, 11);
    put_orange(15, 11);
    send_frame(`CAM_HEIGHT);
    check_next_frame("orange_right");
  endtask

  task automatic test_direction();
    // four left, four right, none in the middle
    fill_random();
    put_orange(0, 1);
    put_orange(4, 2);
    put_orange(2, 6);
    put_orange(1, 10);
    put_orange(11, 1);
    put_orange(15, 2);
    put_orange(12, 6);
    put_orange(14, 10);
    send_frame(`CAM_HEIGHT);
    check_next_frame("dir_center");
    fill_random();
    send_frame(`CAM_HEIGHT);
    check_next_frame("dir_none");
    // left bin wins over one center and one right
    fill_random();
    put_orange(3, 0);
    put_orange(4, 5);
    put_orange(0, 8);
    put_orange(5, 4);
    put_orange(13, 9);
    send_frame(`CAM_HEIGHT);
    check_next_frame("dir_left");
  endtask

  // two captures with no pause, reads keep stealing cycles
  task automatic test_contention();
    fill_random();
    send_frame(`CAM_HEIGHT);
    fill_random();
    put_orange(7, 6);
    send_frame(`CAM_HEIGHT);
    check_next_frame("contention");
    checks++;
    if (overrun !== 1'b0) begin
      $display("contention: overrun went high, a captured pixel was dropped");
      errors++;
    end
  endtask

  // half a frame, then a new vsync and a full frame
  task automatic test_restart();
    fill_random();
    send_frame(5);
    fill_random();
    send_frame(`CAM_HEIGHT);
    check_next_frame("restart");
  endtask

  initial begin
    clk       = 1'b0;
    arst_n    = 1'b0;
    cam_vsync = 1'b0;
    cam_href  = 1'b0;
    cam_data  = 8'h00;
    lcg_state = 32'd64872;
    errors    = 0;
    checks    = 0;
    cycles    = 0;

    test_reset();
    test_round_trip();
    test_orange_right();
    test_direction();
    test_contention();
    test_restart();

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- rtl/cam_top.sv
/* camera to vga frame path
   capture, shared frame buffer, raster scan and orange target reporting */
`include "cam_macros.svh"

module cam_top (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 cam_vsync,
  input  logic                 cam_href,
  input  logic [7:0]           cam_data,
  output logic [7:0]           vga_r,
  output logic [7:0]           vga_g,
  output logic [7:0]           vga_b,
  output logic                 vga_hsync_n,
  output logic                 vga_vsync_n,
  output logic                 vga_blank_n,
  output logic                 vga_pix_clk,
  output logic [`FB_ADDR_W:0]  target_count,
  output cam_pkg::target_dir_e target_dir,
  output logic                 overrun
);
  import cam_pkg::*;

  // write channel
  logic     wr_valid;
  logic     wr_ready;
  fb_addr_t wr_addr;
  pixel_t   wr_pixel;
  // read channel
  logic     rd_valid;
  logic     rd_ready;
  fb_addr_t rd_addr;
  pixel_t   rd_pixel;
  // memory port
  logic     mem_en;
  logic     mem_we;
  fb_addr_t mem_addr;
  pixel_t   mem_wdata;
  pixel_t   mem_rdata;
  // scan timing aligned with rd_pixel
  logic     pix_tick;
  logic     active;
  logic     hsync_n;
  logic     vsync_n;

  ov7670_capture capture_i (
    .clk(clk), .arst_n(arst_n),
    .cam_vsync(cam_vsync), .cam_href(cam_href), .cam_data(cam_data),
    .wr_valid(wr_valid), .wr_addr(wr_addr), .wr_pixel(wr_pixel),
    .wr_ready(wr_ready), .overrun(overrun)
  );

  frame_buffer_arbiter arbiter_i (
    .clk(clk), .arst_n(arst_n),
    .rd_valid(rd_valid), .rd_addr(rd_addr), .rd_ready(rd_ready), .rd_pixel(rd_pixel),
    .wr_valid(wr_valid), .wr_addr(wr_addr), .wr_pixel(wr_pixel), .wr_ready(wr_ready),
    .mem_en(mem_en), .mem_we(mem_we), .mem_addr(mem_addr),
    .mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
  );

  frame_buffer buffer_i (
    .clk(clk), .en(mem_en), .we(mem_we), .addr(mem_addr),
    .wdata(mem_wdata), .rdata(mem_rdata)
  );

  vga_scan scan_i (
    .clk(clk), .arst_n(arst_n),
    .rd_valid(rd_valid), .rd_addr(rd_addr), .rd_ready(rd_ready),
    .pix_tick(pix_tick), .active(active), .hsync_n(hsync_n), .vsync_n(vsync_n)
  );

  target_finder finder_i (
    .clk(clk), .arst_n(arst_n),
    .pix_tick(pix_tick), .active(active), .hsync_n(hsync_n), .vsync_n(vsync_n),
    .pixel(rd_pixel),
    .vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b),
    .vga_blank_n(vga_blank_n), .vga_hsync_n(vga_hsync_n),
    .vga_vsync_n(vga_vsync_n), .vga_pix_clk(vga_pix_clk),
    .target_count(target_count), .target_dir(target_dir)
  );

endmodule

//--- rtl/target_finder.sv
/* orange target finder
   recolours orange pixels, drives vga colour and reports count and direction per frame */
`include "cam_macros.svh"

module target_finder (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 pix_tick,
  input  logic                 active,
  input  logic                 hsync_n,
  input  logic                 vsync_n,
  input  cam_pkg::pixel_t      pixel,
  output logic [7:0]           vga_r,
  output logic [7:0]           vga_g,
  output logic [7:0]           vga_b,
  output logic                 vga_blank_n,
  output logic                 vga_hsync_n,
  output logic                 vga_vsync_n,
  output logic                 vga_pix_clk,
  output logic [`FB_ADDR_W:0]  target_count,
  output cam_pkg::target_dir_e target_dir
);
  import cam_pkg::*;

  // column bins 0..4, 5..10, 11..15
  localparam int LEFT_END    = 5;
  localparam int RIGHT_START = 11;
  localparam int CW          = $clog2(`CAM_WIDTH + 1);

  logic                is_orange;
  pixel_t              pix_out;
  logic [CW-1:0]       col;
  logic [`FB_ADDR_W:0] bin_l;
  logic [`FB_ADDR_W:0] bin_c;
  logic [`FB_ADDR_W:0] bin_r;
  logic [`FB_ADDR_W:0] bin_sum;
  logic                frame_end;
  target_dir_e         dir_next;

  assign is_orange = (pixel.r >= 4'(`ORANGE_R_MIN)) &&
                     (pixel.g >= 4'(`ORANGE_G_MIN)) && (pixel.g <= 4'(`ORANGE_G_MAX)) &&
                     (pixel.b <= 4'(`ORANGE_B_MAX));
  // targets shown as magenta
  assign pix_out   = is_orange ? '{r: 4'hf, g: 4'h0, b: 4'hf} : pixel;
  // falling edge of vertical sync closes the frame
  assign frame_end = vga_vsync_n & ~vsync_n;
  assign bin_sum   = bin_l + bin_c + bin_r;

  // strict winner, otherwise center
  always_comb begin
    if (bin_sum == '0) begin
      dir_next = DIR_NONE;
    end else if ((bin_l > bin_c) && (bin_l > bin_r)) begin
      dir_next = DIR_LEFT;
    end else if ((bin_r > bin_l) && (bin_r > bin_c)) begin
      dir_next = DIR_RIGHT;
    end else begin
      dir_next = DIR_CENTER;
    end
  end

  // sync, blank and pixel clock, one more register stage
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      vga_hsync_n <= 1'b1;
      vga_vsync_n <= 1'b1;
      vga_blank_n <= 1'b0;
      vga_pix_clk <= 1'b0;
    end else begin
      vga_hsync_n <= hsync_n;
      vga_vsync_n <= vsync_n;
      vga_blank_n <= active;
      // rises mid-pixel while colour is stable
      vga_pix_clk <= ~pix_tick;
    end
  end

  // nibble replication, black in blanking
  always_ff @(posedge clk) begin
    vga_r <= active ? {pix_out.r, pix_out.r} : 8'h00;
    vga_g <= active ? {pix_out.g, pix_out.g} : 8'h00;
    vga_b <= active ? {pix_out.b, pix_out.b} : 8'h00;
  end

  // per-frame bins and published result
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      col          <= '0;
      bin_l        <= '0;
      bin_c        <= '0;
      bin_r        <= '0;
      target_count <= '0;
      target_dir   <= DIR_NONE;
    end else if (frame_end) begin
      target_count <= bin_sum;
      target_dir   <= dir_next;
      bin_l        <= '0;
      bin_c        <= '0;
      bin_r        <= '0;
    end else if (!active) begin
      col <= '0;
    end else if (pix_tick) begin
      col <= col + 1'b1;
      if (is_orange) begin
        if (col < CW'(LEFT_END)) begin
          bin_l <= bin_l + 1'b1;
        end else if (col < CW'(RIGHT_START)) begin
          bin_c <= bin_c + 1'b1;
        end else begin
          bin_r <= bin_r + 1'b1;
        end
      end
    end
  end

endmodule

//--- rtl/vga_scan.sv
/* vga raster scan
   pixel tick, sync and blanking timing with raster-order buffer reads */
`include "cam_macros.svh"

module vga_scan (
  input  logic              clk,
  input  logic              arst_n,
  output logic              rd_valid,
  output cam_pkg::fb_addr_t rd_addr,
  input  logic              rd_ready,
  output logic              pix_tick,
  output logic              active,
  output logic              hsync_n,
  output logic              vsync_n
);
  import cam_pkg::*;

  localparam int H_TOTAL   = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
  localparam int V_TOTAL   = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;
  localparam int H_SYNC_LO = `H_ACTIVE + `H_FRONT;
  localparam int V_SYNC_LO = `V_ACTIVE + `V_FRONT;
  localparam int HW        = $clog2(H_TOTAL);
  localparam int VW        = $clog2(V_TOTAL);

  logic          div;
  logic          tick;
  logic [HW-1:0] h_cnt;
  logic [VW-1:0] v_cnt;
  logic          h_last;
  logic          v_last;
  logic          area;
  logic          h_sync_area;
  logic          v_sync_area;

  // pixel rate is half the clock
  assign tick   = div;
  assign h_last = (h_cnt == HW'(H_TOTAL - 1));
  assign v_last = (v_cnt == VW'(V_TOTAL - 1));
  assign area   = (h_cnt < HW'(`H_ACTIVE)) && (v_cnt < VW'(`V_ACTIVE));

  // sync pulses follow the front porch
  assign h_sync_area = (h_cnt >= HW'(H_SYNC_LO)) && (h_cnt < HW'(H_SYNC_LO + `H_SYNC));
  assign v_sync_area = (v_cnt >= VW'(V_SYNC_LO)) && (v_cnt < VW'(V_SYNC_LO + `V_SYNC));

  // one read per active pixel, single clock wide
  assign rd_valid = tick & area;

  // divider and raster counters
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      div   <= 1'b0;
      h_cnt <= '0;
      v_cnt <= '0;
    end else begin
      div <= ~div;
      if (tick) begin
        if (h_last) begin
          h_cnt <= '0;
          v_cnt <= v_last ? '0 : v_cnt + 1'b1;
        end else begin
          h_cnt <= h_cnt + 1'b1;
        end
      end
    end
  end

  // raster address, back to 0 for every frame
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_addr <= '0;
    end else if (tick && h_last && v_last) begin
      rd_addr <= '0;
    end else if (rd_valid && rd_ready) begin
      rd_addr <= (rd_addr == fb_addr_t'(`FB_DEPTH - 1)) ? '0 : rd_addr + 1'b1;
    end
  end

  // timing delayed one clock to meet the read data
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pix_tick <= 1'b0;
      active   <= 1'b0;
      hsync_n  <= 1'b1;
      vsync_n  <= 1'b1;
    end else begin
      pix_tick <= tick;
      active   <= area;
      hsync_n  <= ~h_sync_area;
      vsync_n  <= ~v_sync_area;
    end
  end

endmodule

//--- rtl/frame_buffer.sv
/* single-port frame buffer
   one rgb444 word per pixel with registered read data */
`include "cam_macros.svh"

module frame_buffer (
  input  logic              clk,
  input  logic              en,
  input  logic              we,
  input  cam_pkg::fb_addr_t addr,
  input  cam_pkg::pixel_t   wdata,
  output cam_pkg::pixel_t   rdata
);
  import cam_pkg::*;

  // one frame of pixels
  pixel_t mem [0:`FB_DEPTH-1];

  // write or read per enabled clock, never both
  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        mem[addr] <= wdata;
      end else begin
        // read data valid the clock after the request
        rdata <= mem[addr];
      end
    end
  end

endmodule

//--- rtl/frame_buffer_arbiter.sv
/* frame buffer port arbiter
   shares one memory port, display reads first, capture writes in the gaps */
module frame_buffer_arbiter (
  input  logic              clk,
  input  logic              arst_n,
  // display read channel
  input  logic              rd_valid,
  input  cam_pkg::fb_addr_t rd_addr,
  output logic              rd_ready,
  output cam_pkg::pixel_t   rd_pixel,
  // capture write channel
  input  logic              wr_valid,
  input  cam_pkg::fb_addr_t wr_addr,
  input  cam_pkg::pixel_t   wr_pixel,
  output logic              wr_ready,
  // single memory port
  output logic              mem_en,
  output logic              mem_we,
  output cam_pkg::fb_addr_t mem_addr,
  output cam_pkg::pixel_t   mem_wdata,
  input  cam_pkg::pixel_t   mem_rdata
);
  import cam_pkg::*;

  logic   rd_grant;
  logic   wr_grant;
  logic   rd_done;
  pixel_t rd_hold;

  // display is never stalled
  assign rd_ready = 1'b1;
  // writer only gets cycles the reader leaves idle
  assign wr_ready = ~rd_valid;

  assign rd_grant = rd_valid & rd_ready;
  assign wr_grant = wr_valid & wr_ready;

  // steer the granted request onto the port
  assign mem_en    = rd_grant | wr_grant;
  assign mem_we    = wr_grant;
  assign mem_addr  = rd_grant ? rd_addr : wr_addr;
  assign mem_wdata = wr_pixel;

  // marks the clock where mem_rdata answers a read
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_done <= 1'b0;
    end else begin
      rd_done <= rd_grant;
    end
  end

  // keep the last read word for the clocks in between
  always_ff @(posedge clk) begin
    if (rd_done) begin
      rd_hold <= mem_rdata;
    end
  end

  // fresh data passes straight through, otherwise the held copy
  assign rd_pixel = rd_done ? mem_rdata : rd_hold;

endmodule

//--- rtl/ov7670_capture.sv
/* ov7670 byte-stream capture
   packs byte pairs into rgb444 pixels and raises frame-buffer write requests */
`include "cam_macros.svh"

module ov7670_capture (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              cam_vsync,
  input  logic              cam_href,
  input  logic [7:0]        cam_data,
  output logic              wr_valid,
  output cam_pkg::fb_addr_t wr_addr,
  output cam_pkg::pixel_t   wr_pixel,
  input  logic              wr_ready,
  output logic              overrun
);
  import cam_pkg::*;

  logic       byte_phase;
  logic [3:0] red_hold;
  fb_addr_t   pix_addr;
  logic       frame_full;
  logic       pair_done;
  logic       wr_pending;
  logic       accept;
  logic       drop;

  // second byte of a pair lands this clock
  assign pair_done  = cam_href & byte_phase & ~cam_vsync;
  // holding register still waiting for a grant
  assign wr_pending = wr_valid & ~wr_ready;
  // pixels beyond one frame are ignored
  assign frame_full = (pix_addr == fb_addr_t'(`FB_DEPTH));
  assign accept     = pair_done & ~frame_full & ~wr_pending;
  assign drop       = pair_done & ~frame_full & wr_pending;

  // byte phase and pixel address
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      byte_phase <= 1'b0;
      pix_addr   <= '0;
    end else if (cam_vsync) begin
      // new frame, restart at address 0
      byte_phase <= 1'b0;
      pix_addr   <= '0;
    end else if (!cam_href) begin
      // realign pairs at each line start
      byte_phase <= 1'b0;
    end else begin
      byte_phase <= ~byte_phase;
      // address moves even when a pixel is dropped, keeps raster order
      if (byte_phase && !frame_full) begin
        pix_addr <= pix_addr + 1'b1;
      end
    end
  end

  // first byte carries red in its low nibble
  always_ff @(posedge clk) begin
    if (cam_href && !byte_phase) begin
      red_hold <= cam_data[3:0];
    end
  end

  // one-entry write request, cleared on grant
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_valid <= 1'b0;
      overrun  <= 1'b0;
    end else begin
      if (accept) begin
        wr_valid <= 1'b1;
      end else if (wr_ready) begin
        wr_valid <= 1'b0;
      end
      // sticky until reset
      if (drop) begin
        overrun <= 1'b1;
      end
    end
  end

  // second byte gives green then blue
  always_ff @(posedge clk) begin
    if (accept) begin
      wr_addr  <= pix_addr;
      wr_pixel <= '{r: red_hold, g: cam_data[7:4], b: cam_data[3:0]};
    end
  end

endmodule

//--- rtl/cam_pkg.sv
/* camera frame path types
   pixel word, buffer address and target direction shared across the design */
`include "cam_macros.svh"

package cam_pkg;

  // rgb444 pixel as captured and stored
  // red sits in the top nibble, blue in the bottom
  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
  } pixel_t;

  // word address into the frame buffer
  // wide enough for one full frame of pixels
  typedef logic [`FB_ADDR_W-1:0] fb_addr_t;

  // which third of the picture holds most target pixels
  // none means no target pixel was seen in the frame
  // center also covers ties between the bins
  typedef enum logic [1:0] {
    DIR_NONE   = 2'd0,
    DIR_LEFT   = 2'd1,
    DIR_CENTER = 2'd2,
    DIR_RIGHT  = 2'd3
  } target_dir_e;

endpackage

//--- rtl/cam_macros.svh
/* camera frame path geometry and thresholds
   frame size, vga timing, buffer addressing and orange colour window */
`ifndef CAM_MACROS_SVH
`define CAM_MACROS_SVH

// active picture, one buffer word per pixel
`define CAM_WIDTH     16
`define CAM_HEIGHT    12

// horizontal timing in pixels
`define H_ACTIVE      16
`define H_FRONT       2
`define H_SYNC        4
`define H_BACK        2

// vertical timing in lines
`define V_ACTIVE      12
`define V_FRONT       1
`define V_SYNC        2
`define V_BACK        1

// buffer holds exactly one frame
`define FB_DEPTH      192
`define FB_ADDR_W     8

// orange window on rgb444 nibbles
`define ORANGE_R_MIN  12
`define ORANGE_G_MIN  4
`define ORANGE_G_MAX  9
`define ORANGE_B_MAX  3

`endif
